// File: include/dbus_defs.svh
`ifndef DBUS_DEFS_SVH
`define DBUS_DEFS_SVH

// core byte address width.
`define DBUS_ADDR_W 32

// data word width seen by the core.
`define DBUS_DATA_W 32

// byte lanes per data word.
`define DBUS_LANES 4

// words held in each byte bank.
// the word address width is log2 of this.
`define DBUS_DEPTH 256

`endif

// File: logic/dbus_cpu_pkg.sv
`include "dbus_defs.svh"

package dbus_cpu_pkg;

    // access size, low two bits of the bus mode.
    typedef enum logic [1:0] {
        SIZE_BYTE = 2'b00,
        SIZE_HALF = 2'b01,
        SIZE_WORD = 2'b10,
        SIZE_BAD  = 2'b11
    } dbus_size_t;

    // bit 2 set means the load is zero extended.
    typedef struct packed {
        logic       is_unsigned;
        dbus_size_t size;
    } dbus_mode_t;

    typedef struct packed {
        logic [`DBUS_ADDR_W-1:0] addr;
        dbus_mode_t              mode;
        logic                    re;
        logic                    we;
        logic [`DBUS_DATA_W-1:0] wd;
    } dbus_cpu_req_t;

endpackage

// File: logic/dbus_mem_pkg.sv
`include "dbus_defs.svh"

package dbus_mem_pkg;

    // request broadcast to every byte bank.
    typedef struct packed {
        logic [$clog2(`DBUS_DEPTH)-1:0] waddr;
        logic                           re;
        logic [`DBUS_LANES-1:0]         be;
        logic [`DBUS_DATA_W-1:0]        wd;
    } dbus_lane_req_t;

    // what the load aligner needs to know about a read in flight.
    typedef struct packed {
        dbus_cpu_pkg::dbus_mode_t       mode;
        logic [$clog2(`DBUS_LANES)-1:0] offset;
        logic                           valid;
    } dbus_load_tag_t;

endpackage

// File: logic/dbus_store_align.sv
`timescale 1ns/1ps

`include "dbus_defs.svh"

module dbus_store_align
    import dbus_cpu_pkg::*;
    import dbus_mem_pkg::*;
(
    input  dbus_cpu_req_t  i_req,
    output dbus_lane_req_t o_lane,
    output dbus_load_tag_t o_tag,
    output logic           o_misaligned
);

    localparam int OFF_W   = $clog2(`DBUS_LANES);
    localparam int WADDR_W = $clog2(`DBUS_DEPTH);

    logic [OFF_W-1:0]        w_off;
    logic [OFF_W+2:0]        w_shift;
    logic                    w_misaligned;
    logic                    w_bad_size;
    logic                    w_ok;
    logic [`DBUS_LANES-1:0]  w_be;
    logic [`DBUS_DATA_W-1:0] w_wd;

    assign w_off   = i_req.addr[OFF_W-1:0];
    assign w_shift = {w_off, 3'b000};

    // enables and lane data per size, zero for anything not aligned.
    always_comb begin
        w_misaligned = 1'b0;
        w_be         = '0;
        w_wd         = '0;
        case (i_req.mode.size)
            SIZE_BYTE: begin
                w_be = `DBUS_LANES'(1) << w_off;
                w_wd = `DBUS_DATA_W'(i_req.wd[7:0]) << w_shift;
            end
            SIZE_HALF: begin
                if (w_off == OFF_W'(`DBUS_LANES - 1)) begin
                    w_misaligned = 1'b1;
                end else begin
                    w_be = `DBUS_LANES'(3) << w_off;
                    w_wd = `DBUS_DATA_W'(i_req.wd[15:0]) << w_shift;
                end
            end
            SIZE_WORD: begin
                if (w_off != '0) begin
                    w_misaligned = 1'b1;
                end else begin
                    w_be = '1;
                    w_wd = i_req.wd;
                end
            end
            default: begin
                w_be = '0;
                w_wd = '0;
            end
        endcase
    end

    // size code 3 is dropped but not flagged.
    assign w_bad_size = (i_req.mode.size == SIZE_BAD);
    assign w_ok       = !w_misaligned && !w_bad_size;

    always_comb begin
        o_lane.waddr = i_req.addr[OFF_W +: WADDR_W];
        o_lane.re    = i_req.re && w_ok;
        o_lane.be    = w_be;
        o_lane.wd    = w_wd;
    end

    always_comb begin
        o_tag.mode   = i_req.mode;
        o_tag.offset = w_off;
        o_tag.valid  = i_req.re && w_ok;
    end

    assign o_misaligned = w_misaligned && (i_req.re || i_req.we);

endmodule

// File: logic/dbus_byte_bank.sv
`timescale 1ns/1ps

`include "dbus_defs.svh"

module dbus_byte_bank
    import dbus_mem_pkg::*;
#(
    parameter int LANE   = 0,
    parameter int BYTE_W = `DBUS_DATA_W / `DBUS_LANES
) (
    input  logic              i_Clk,
    input  logic              i_arst_n,
    input  dbus_lane_req_t    i_lane,
    input  logic              i_we,
    output logic [BYTE_W-1:0] o_byte
);

    logic [BYTE_W-1:0] mem [`DBUS_DEPTH];

    // each bank keeps only its own byte of the lane data.
    always_ff @(posedge i_Clk) begin
        if (i_we) begin
            mem[i_lane.waddr] <= i_lane.wd[LANE*BYTE_W +: BYTE_W];
        end
    end

    // read register holds its value between reads.
    // a read together with a write returns the old byte.
    always_ff @(posedge i_Clk or negedge i_arst_n) begin
        if (!i_arst_n) begin
            o_byte <= '0;
        end else if (i_lane.re) begin
            o_byte <= mem[i_lane.waddr];
        end
    end

endmodule

// File: logic/dbus_load_align.sv
`timescale 1ns/1ps

`include "dbus_defs.svh"

module dbus_load_align
    import dbus_cpu_pkg::*;
    import dbus_mem_pkg::*;
(
    input  logic                                    i_Clk,
    input  logic                                    i_arst_n,
    input  dbus_load_tag_t                          i_tag,
    input  logic [`DBUS_LANES-1:0][`DBUS_DATA_W/`DBUS_LANES-1:0] i_lanes,
    output logic [`DBUS_DATA_W-1:0]                 o_rd,
    output logic                                    o_rd_valid
);

    localparam int OFF_W = $clog2(`DBUS_LANES);

    dbus_load_tag_t          r_tag;
    logic [`DBUS_DATA_W-1:0] w_word;
    logic [`DBUS_DATA_W-1:0] w_shifted;
    logic [OFF_W+2:0]        w_shift;
    logic                    w_signed;
    logic                    w_ext;

    // tag lines up with the bank read registers.
    always_ff @(posedge i_Clk or negedge i_arst_n) begin
        if (!i_arst_n) begin
            r_tag <= '0;
        end else begin
            r_tag <= i_tag;
        end
    end

    // lane 0 is the least significant byte.
    assign w_word    = i_lanes;
    assign w_shift   = {r_tag.offset, 3'b000};
    assign w_shifted = w_word >> w_shift;
    assign w_signed  = !r_tag.mode.is_unsigned;

    always_comb begin
        w_ext = 1'b0;
        o_rd  = '0;
        if (r_tag.valid) begin
            case (r_tag.mode.size)
                SIZE_BYTE: begin
                    w_ext = w_signed && w_shifted[7];
                    o_rd  = {{(`DBUS_DATA_W-8){w_ext}}, w_shifted[7:0]};
                end
                SIZE_HALF: begin
                    w_ext = w_signed && w_shifted[15];
                    o_rd  = {{(`DBUS_DATA_W-16){w_ext}}, w_shifted[15:0]};
                end
                SIZE_WORD: begin
                    o_rd = w_word;
                end
                default: begin
                    // never tagged valid.
                    o_rd = '0;
                end
            endcase
        end
    end

    assign o_rd_valid = r_tag.valid;

endmodule

// File: logic/dbus_subsystem.sv
`timescale 1ns/1ps

`include "dbus_defs.svh"

module dbus_subsystem
    import dbus_cpu_pkg::*;
    import dbus_mem_pkg::*;
(
    input  logic                    i_Clk,
    input  logic                    i_arst_n,
    input  logic [`DBUS_ADDR_W-1:0] i_addr,
    input  dbus_mode_t              i_mode,
    input  logic                    i_re,
    input  logic                    i_we,
    input  logic [`DBUS_DATA_W-1:0] i_wd,
    output logic [`DBUS_DATA_W-1:0] o_rd,
    output logic                    o_rd_valid,
    output logic                    o_misaligned
);

    localparam int BYTE_W = `DBUS_DATA_W / `DBUS_LANES;

    dbus_cpu_req_t                         w_req;
    dbus_lane_req_t                        w_lane;
    dbus_load_tag_t                        w_tag;
    logic [`DBUS_LANES-1:0][BYTE_W-1:0]    w_lanes;

    always_comb begin
        w_req.addr = i_addr;
        w_req.mode = i_mode;
        w_req.re   = i_re;
        w_req.we   = i_we;
        w_req.wd   = i_wd;
    end

    dbus_store_align u_store_align (
        .i_req        (w_req),
        .o_lane       (w_lane),
        .o_tag        (w_tag),
        .o_misaligned (o_misaligned)
    );

    // byte enables are already cleared for bad accesses.
    for (genvar g = 0; g < `DBUS_LANES; g++) begin : g_bank
        dbus_byte_bank #(
            .LANE   (g),
            .BYTE_W (BYTE_W)
        ) u_bank (
            .i_Clk    (i_Clk),
            .i_arst_n (i_arst_n),
            .i_lane   (w_lane),
            .i_we     (i_we && w_lane.be[g]),
            .o_byte   (w_lanes[g])
        );
    end

    dbus_load_align u_load_align (
        .i_Clk      (i_Clk),
        .i_arst_n   (i_arst_n),
        .i_tag      (w_tag),
        .i_lanes    (w_lanes),
        .o_rd       (o_rd),
        .o_rd_valid (o_rd_valid)
    );

endmodule

// File: tests/dbus_tb.sv
`timescale 1ns/1ps

`include "dbus_defs.svh"

module dbus_tb
    import dbus_cpu_pkg::*;
;

    localparam int CLK_PERIOD = 100;
    localparam int TABLE_LEN  = 29;
    localparam int NUM_RANDOM = 40;
    localparam int RAND_SEED  = 14;
    localparam int MODEL_SIZE = `DBUS_DEPTH * `DBUS_LANES;
    localparam int WATCHDOG_NS = (TABLE_LEN + NUM_RANDOM + 10) * CLK_PERIOD;

    // one table row, with the expected misalignment flag.
    typedef struct packed {
        logic                    re;
        logic                    we;
        dbus_mode_t              mode;
        logic [`DBUS_ADDR_W-1:0] addr;
        logic [`DBUS_DATA_W-1:0] wd;
        logic                    exp_mis;
    } stim_t;

    logic                    i_Clk;
    logic                    i_arst_n;
    logic [`DBUS_ADDR_W-1:0] i_addr;
    dbus_mode_t              i_mode;
    logic                    i_re;
    logic                    i_we;
    logic [`DBUS_DATA_W-1:0] i_wd;
    logic [`DBUS_DATA_W-1:0] o_rd;
    logic                    o_rd_valid;
    logic                    o_misaligned;

    stim_t                   stim_table [TABLE_LEN];
    logic [7:0]              model_mem [MODEL_SIZE];
    logic                    exp_valid;
    logic [`DBUS_DATA_W-1:0] exp_rd;
    int                      n_checks;
    int                      n_errors;

    dbus_subsystem DUT (
        .i_Clk        (i_Clk),
        .i_arst_n     (i_arst_n),
        .i_addr       (i_addr),
        .i_mode       (i_mode),
        .i_re         (i_re),
        .i_we         (i_we),
        .i_wd         (i_wd),
        .o_rd         (o_rd),
        .o_rd_valid   (o_rd_valid),
        .o_misaligned (o_misaligned)
    );

    initial begin
        i_Clk = 1'b0;
        forever #(CLK_PERIOD / 2) i_Clk = ~i_Clk;
    end

    task automatic check_value(input string name, input logic [31:0] actual,
                               input logic [31:0] expected);
        n_checks++;
        if (actual !== expected) begin
            n_errors++;
            $display("CHECK FAILED: %s actual=0x%h expected=0x%h at %0t",
                     name, actual, expected, $time);
        end
    endtask

    function automatic stim_t make_stim(input logic re, input logic we, input logic uns,
                                        input dbus_size_t size, input logic [31:0] addr,
                                        input logic [31:0] wd, input logic mis);
        stim_t s;
        s.re               = re;
        s.we               = we;
        s.mode.is_unsigned = uns;
        s.mode.size        = size;
        s.addr             = addr;
        s.wd               = wd;
        s.exp_mis          = mis;
        return s;
    endfunction

    function automatic int size_bytes(input dbus_mode_t mode);
        case (mode.size)
            SIZE_BYTE: return 1;
            SIZE_HALF: return 2;
            default:   return 4;
        endcase
    endfunction

    // a half word may not cross into the next word and a word must start at offset 0.
    function automatic logic is_misaligned(input dbus_mode_t mode, input logic [31:0] addr);
        return (mode.size == SIZE_HALF && addr[1:0] == 2'd3) ||
               (mode.size == SIZE_WORD && addr[1:0] != 2'd0);
    endfunction

    function automatic logic [31:0] model_load(input dbus_mode_t mode, input logic [31:0] addr);
        logic [31:0] value;
        int          n;
        int          i;
        value = '0;
        n     = size_bytes(mode);
        for (i = 0; i < n; i++) begin
            value[8*i +: 8] = model_mem[int'(addr[9:0]) + i];
        end
        if (!mode.is_unsigned && n < 4 && value[8*n-1]) begin
            for (i = n; i < 4; i++) begin
                value[8*i +: 8] = 8'hFF;
            end
        end
        return value;
    endfunction

    task automatic model_store(input dbus_mode_t mode, input logic [31:0] addr,
                               input logic [31:0] wd);
        int i;
        for (i = 0; i < size_bytes(mode); i++) begin
            model_mem[int'(addr[9:0]) + i] = wd[8*i +: 8];
        end
    endtask

    // checks the previous cycle's load, then issues one request.
    task automatic run_op(input stim_t s);
        logic ok;
        @(negedge i_Clk);
        check_value("o_rd_valid", o_rd_valid, exp_valid);
        check_value("o_rd", o_rd, exp_rd);
        i_re   = s.re;
        i_we   = s.we;
        i_mode = s.mode;
        i_addr = s.addr;
        i_wd   = s.wd;
        #(CLK_PERIOD / 4);
        check_value("o_misaligned", o_misaligned, s.exp_mis);
        ok        = !is_misaligned(s.mode, s.addr) && (s.mode.size != SIZE_BAD);
        exp_valid = s.re && ok;
        exp_rd    = exp_valid ? model_load(s.mode, s.addr) : '0;
        // the read sees the old contents when both strobes are set.
        if (s.we && ok) begin
            model_store(s.mode, s.addr, s.wd);
        end
    endtask

    task automatic fill_table();
        stim_table[0]  = make_stim(0, 1, 0, SIZE_WORD, 32'h00, 32'h11223344, 0);
        stim_table[1]  = make_stim(0, 1, 0, SIZE_WORD, 32'h04, 32'h55667788, 0);
        stim_table[2]  = make_stim(0, 1, 0, SIZE_WORD, 32'h08, 32'h99AABBCC, 0);
        stim_table[3]  = make_stim(0, 1, 0, SIZE_WORD, 32'h0C, 32'hDDEEFF00, 0);
        stim_table[4]  = make_stim(1, 0, 0, SIZE_WORD, 32'h00, 32'h0, 0);
        stim_table[5]  = make_stim(0, 1, 0, SIZE_BYTE, 32'h04, 32'h5A5A5AA0, 0);
        stim_table[6]  = make_stim(0, 1, 0, SIZE_BYTE, 32'h07, 32'h5A5A5AD3, 0);
        stim_table[7]  = make_stim(1, 0, 0, SIZE_WORD, 32'h04, 32'h0, 0);
        stim_table[8]  = make_stim(0, 1, 0, SIZE_BYTE, 32'h09, 32'h000000E1, 0);
        stim_table[9]  = make_stim(0, 1, 0, SIZE_BYTE, 32'h0A, 32'h000000F2, 0);
        stim_table[10] = make_stim(1, 0, 0, SIZE_WORD, 32'h08, 32'h0, 0);
        stim_table[11] = make_stim(1, 0, 0, SIZE_BYTE, 32'h07, 32'h0, 0);
        stim_table[12] = make_stim(1, 0, 1, SIZE_BYTE, 32'h07, 32'h0, 0);
        stim_table[13] = make_stim(0, 1, 0, SIZE_HALF, 32'h0C, 32'h00008001, 0);
        stim_table[14] = make_stim(0, 1, 0, SIZE_HALF, 32'h0E, 32'h00001234, 0);
        stim_table[15] = make_stim(1, 0, 0, SIZE_HALF, 32'h0C, 32'h0, 0);
        stim_table[16] = make_stim(1, 0, 1, SIZE_HALF, 32'h0D, 32'h0, 0);
        stim_table[17] = make_stim(1, 0, 0, SIZE_HALF, 32'h0E, 32'h0, 0);
        stim_table[18] = make_stim(0, 1, 0, SIZE_HALF, 32'h01, 32'h0000BEEF, 0);
        stim_table[19] = make_stim(1, 0, 0, SIZE_WORD, 32'h00, 32'h0, 0);
        stim_table[20] = make_stim(0, 1, 0, SIZE_HALF, 32'h03, 32'h0000FFFF, 1);
        stim_table[21] = make_stim(0, 1, 0, SIZE_WORD, 32'h06, 32'hFFFFFFFF, 1);
        stim_table[22] = make_stim(1, 0, 0, SIZE_WORD, 32'h02, 32'h0, 1);
        stim_table[23] = make_stim(0, 1, 0, SIZE_BAD,  32'h00, 32'hFFFFFFFF, 0);
        stim_table[24] = make_stim(1, 0, 0, SIZE_BAD,  32'h00, 32'h0, 0);
        stim_table[25] = make_stim(1, 0, 0, SIZE_WORD, 32'h00, 32'h0, 0);
        stim_table[26] = make_stim(1, 1, 0, SIZE_WORD, 32'h08, 32'h0BADF00D, 0);
        stim_table[27] = make_stim(1, 0, 0, SIZE_WORD, 32'h08, 32'h0, 0);
        stim_table[28] = make_stim(1, 0, 0, SIZE_WORD, 32'h04, 32'h0, 0);
    endtask

    initial begin
        stim_t s;
        int    k;
        void'($urandom(RAND_SEED));
        i_arst_n  = 1'b0;
        i_addr    = '0;
        i_mode    = '0;
        i_re      = 1'b0;
        i_we      = 1'b0;
        i_wd      = '0;
        exp_valid = 1'b0;
        exp_rd    = '0;
        n_checks  = 0;
        n_errors  = 0;
        fill_table();
        repeat (2) @(posedge i_Clk);
        @(negedge i_Clk);
        i_arst_n = 1'b1;
        check_value("o_rd_valid", o_rd_valid, 1'b0);
        check_value("o_rd", o_rd, 32'h0);

        for (k = 0; k < TABLE_LEN; k++) begin
            run_op(stim_table[k]);
        end

        // random traffic stays inside the four words the table initialized.
        for (k = 0; k < NUM_RANDOM; k++) begin
            s = make_stim($urandom_range(1, 0), $urandom_range(1, 0), $urandom_range(1, 0),
                          dbus_size_t'($urandom_range(3, 0)), 32'($urandom_range(15, 0)),
                          $urandom(), 1'b0);
            s.exp_mis = is_misaligned(s.mode, s.addr) && (s.re || s.we);
            run_op(s);
        end
        run_op(make_stim(0, 0, 0, SIZE_BYTE, 32'h0, 32'h0, 0));
        @(negedge i_Clk);
        check_value("o_rd_valid", o_rd_valid, exp_valid);
        check_value("o_rd", o_rd, exp_rd);

        $display("checks: %0d, errors: %0d", n_checks, n_errors);
        if (n_errors == 0) begin
            $display("Testbench passed");
        end else begin
            $display("Testbench failed");
        end
        $finish;
    end

    initial begin
        #(WATCHDOG_NS);
        $display("timeout: the run did not finish within %0d ns", WATCHDOG_NS);
        $display("Testbench failed");
        $finish;
    end

endmodule

// File: list.f
+incdir+include
logic/dbus_cpu_pkg.sv
logic/dbus_mem_pkg.sv
logic/dbus_store_align.sv
logic/dbus_byte_bank.sv
logic/dbus_load_align.sv
logic/dbus_subsystem.sv
tests/dbus_tb.sv

// File: Bender.yml
package:
  name: dbus_subsystem

export_include_dirs:
  - include

sources:
  - include_dirs:
      - include
    files:
      - logic/dbus_cpu_pkg.sv
      - logic/dbus_mem_pkg.sv
      - logic/dbus_store_align.sv
      - logic/dbus_byte_bank.sv
      - logic/dbus_load_align.sv
      - logic/dbus_subsystem.sv
  - target: simulation
    include_dirs:
      - include
    files:
      - tests/dbus_tb.sv
